// ==== common/bergen_defs.svh ====
`ifndef BERGEN_DEFS_SVH
`define BERGEN_DEFS_SVH

// usb bus geometry
`define BERGEN_USB_ADDR_W 20
`define BERGEN_BYTECNT_W 7

// heartbeat counter widths, top bit drives an led
`define BERGEN_HB_USB_W 25
`define BERGEN_HB_SYS_W 23

// sysclk frequency measurement
`define BERGEN_FREQ_W 32
`define BERGEN_FREQ_GATE_BIT 22

`endif

// ==== common/bergen_bus_pkg.sv ====
`include "bergen_defs.svh"

package bergen_bus_pkg;

   // full address as driven by the usb master
   typedef logic [`BERGEN_USB_ADDR_W-1:0] usb_addr_t;

   // register number, upper part of the usb address
   typedef logic [`BERGEN_USB_ADDR_W-`BERGEN_BYTECNT_W-1:0] reg_addr_t;

   // byte index inside a multi-byte register
   typedef logic [`BERGEN_BYTECNT_W-1:0] bytecnt_t;

   typedef logic [7:0] bus_byte_t;

endpackage

// ==== common/bergen_reg_pkg.sv ====
`include "bergen_defs.svh"

package bergen_reg_pkg;

   typedef logic [`BERGEN_FREQ_W-1:0] freq_t; // sysclk cycles per gate

   typedef enum logic [1:0] {
      FE_IDLE,
      FE_WRITE,
      FE_READ
   } fe_state_t;

   // register map
   localparam bergen_bus_pkg::reg_addr_t REG_IDENT       = 'd0; // ro, constant
   localparam bergen_bus_pkg::reg_addr_t REG_LEDS        = 'd1; // rw, 8 bits
   localparam bergen_bus_pkg::reg_addr_t REG_HB_SEL      = 'd2; // rw, bit 0
   localparam bergen_bus_pkg::reg_addr_t REG_DIP         = 'd3; // ro, switches
   localparam bergen_bus_pkg::reg_addr_t REG_SYSCLK_FREQ = 'd4; // ro, 4 bytes, lsb first

   localparam bergen_bus_pkg::bus_byte_t IDENT_VALUE = 8'h2E;

endpackage

// ==== freq/cdc_pulse.sv ====
`timescale 1ns/1ns

module cdc_pulse (
   input  logic reset,
   input  logic src_clk_i,
   input  logic src_pulse_i,
   input  logic dst_clk_i,
   output logic dst_pulse_o
);

   logic       src_toggle;
   logic [2:0] dst_sync; // [0],[1] synchronizer, [2] edge history

   // each source pulse flips the level, so nothing is lost on a slow dst clock
   always_ff @(posedge src_clk_i) begin
      if (reset) begin
         src_toggle <= 1'b0;
      end else if (src_pulse_i) begin
         src_toggle <= ~src_toggle;
      end
   end

   always_ff @(posedge dst_clk_i) begin
      dst_sync <= {dst_sync[1:0], src_toggle};
   end

   assign dst_pulse_o = dst_sync[2] ^ dst_sync[1]; // any level change is one pulse

endmodule

// ==== freq/sysclk_freq_meter.sv ====
`timescale 1ns/1ns
`include "bergen_defs.svh"

module sysclk_freq_meter #(
   parameter int FREQ_GATE_BIT = `BERGEN_FREQ_GATE_BIT
) (
   input  logic                  usb_clk_buf,
   input  logic                  reset,
   input  logic                  sysclk_i,
   output bergen_reg_pkg::freq_t freq_o
);
   import bergen_reg_pkg::*;

   typedef logic [FREQ_GATE_BIT:0] gate_timer_t;

   gate_timer_t timer_q;
   logic        gate_bit_q;
   logic        gate_pulse;
   logic        gate_sys;
   freq_t       count_q;

   // gate every 2^(FREQ_GATE_BIT+1) usb cycles
   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         timer_q    <= '0;
         gate_bit_q <= 1'b0;
         gate_pulse <= 1'b0;
      end else begin
         timer_q    <= timer_q + gate_timer_t'(1);
         gate_bit_q <= timer_q[FREQ_GATE_BIT];
         gate_pulse <= timer_q[FREQ_GATE_BIT] & ~gate_bit_q; // rising edge only
      end
   end

   cdc_pulse u_gate_cdc (
      .reset       (reset),
      .src_clk_i   (usb_clk_buf),
      .src_pulse_i (gate_pulse),
      .dst_clk_i   (sysclk_i),
      .dst_pulse_o (gate_sys)
   );

   // first value is garbage until one full gate has passed
   always_ff @(posedge sysclk_i) begin
      if (gate_sys) begin
         count_q <= freq_t'(1); // gate cycle counts as the first
         freq_o  <= count_q;
      end else begin
         count_q <= count_q + freq_t'(1);
      end
   end

   a_gate_one_cycle: assert property (@(posedge usb_clk_buf) disable iff (reset)
      gate_pulse |=> !gate_pulse);

endmodule

// ==== regs/bergen_reg_bank.sv ====
`timescale 1ns/1ns

module bergen_reg_bank (
   input  logic                      usb_clk_buf,
   input  logic                      reset,
   input  bergen_bus_pkg::reg_addr_t reg_addr_i,
   input  bergen_bus_pkg::bytecnt_t  reg_bytecnt_i,
   input  bergen_bus_pkg::bus_byte_t reg_wdata_i,
   input  logic                      reg_write_i,
   input  logic                      reg_read_i,
   input  bergen_bus_pkg::bus_byte_t dip_i,
   input  bergen_reg_pkg::freq_t     freq_i,
   output bergen_bus_pkg::bus_byte_t reg_rdata_o,
   output bergen_bus_pkg::bus_byte_t reg_leds_o,
   output logic                      hb_sel_o
);
   import bergen_bus_pkg::*;
   import bergen_reg_pkg::*;

   bus_byte_t leds_q;
   logic      hb_sel_q;
   bus_byte_t freq_byte;
   bus_byte_t rdata;

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         leds_q   <= '0;
         hb_sel_q <= 1'b0;
      end else if (reg_write_i) begin
         case (reg_addr_i)
            REG_LEDS:   leds_q   <= reg_wdata_i;
            REG_HB_SEL: hb_sel_q <= reg_wdata_i[0];
            default:    ; // read-only or unmapped, write dropped
         endcase
      end
   end

   assign reg_leds_o = leds_q;
   assign hb_sel_o   = hb_sel_q;

   // freq_i comes from sysclk but only changes once per gate,
   // long before the host gets around to reading it
   always_comb begin
      case (reg_bytecnt_i)
         7'd0:    freq_byte = freq_i[7:0];
         7'd1:    freq_byte = freq_i[15:8];
         7'd2:    freq_byte = freq_i[23:16];
         7'd3:    freq_byte = freq_i[31:24];
         default: freq_byte = '0;
      endcase
   end

   always_comb begin
      case (reg_addr_i)
         REG_IDENT:       rdata = IDENT_VALUE;
         REG_LEDS:        rdata = leds_q;
         REG_HB_SEL:      rdata = {7'b0, hb_sel_q};
         REG_DIP:         rdata = dip_i;
         REG_SYSCLK_FREQ: rdata = freq_byte;
         default:         rdata = '0; // unmapped reads as zero
      endcase
   end

   assign reg_rdata_o = reg_read_i ? rdata : '0;

   a_ro_untouched: assert property (@(posedge usb_clk_buf) disable iff (reset)
      reg_write_i && (reg_addr_i != REG_LEDS) && (reg_addr_i != REG_HB_SEL)
      |=> $stable(leds_q) && $stable(hb_sel_q));

endmodule

// ==== verilog/usb_reg_fe.sv ====
`timescale 1ns/1ns

module usb_reg_fe (
   input  logic                      usb_clk_buf,
   input  logic                      reset,
   input  bergen_bus_pkg::usb_addr_t usb_addr_i,
   input  bergen_bus_pkg::bus_byte_t usb_data_i,
   input  logic                      usb_nrd_i,
   input  logic                      usb_nwr_i,
   input  logic                      usb_nce_i,
   input  bergen_bus_pkg::bus_byte_t reg_rdata_i,
   output bergen_bus_pkg::bus_byte_t usb_data_o,
   output logic                      usb_isout_o,
   output bergen_bus_pkg::reg_addr_t reg_addr_o,
   output bergen_bus_pkg::bytecnt_t  reg_bytecnt_o,
   output bergen_bus_pkg::bus_byte_t reg_wdata_o,
   output logic                      reg_write_o,
   output logic                      reg_read_o
);
   import bergen_bus_pkg::*;
   import bergen_reg_pkg::*;

   usb_addr_t addr_q;
   bus_byte_t wdata_q;
   logic      nrd_q;
   logic      nwr_q;
   logic      nce_q;
   logic      wr_sel;
   logic      rd_sel;
   fe_state_t state;

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         nrd_q <= 1'b1;
         nwr_q <= 1'b1;
         nce_q <= 1'b1;
      end else begin
         nrd_q <= usb_nrd_i;
         nwr_q <= usb_nwr_i;
         nce_q <= usb_nce_i;
      end
   end

   always_ff @(posedge usb_clk_buf) begin
      addr_q  <= usb_addr_i; // master keeps these steady under a strobe
      wdata_q <= usb_data_i;
   end

   assign wr_sel = ~nwr_q & ~nce_q;
   assign rd_sel = ~nrd_q & ~nce_q;

   assign {reg_addr_o, reg_bytecnt_o} = addr_q; // register number above byte index
   assign reg_wdata_o = wdata_q;
   assign reg_read_o  = (state == FE_READ);

   // one write pulse per strobe, read held for the whole strobe
   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         state       <= FE_IDLE;
         reg_write_o <= 1'b0;
         usb_isout_o <= 1'b0;
      end else begin
         reg_write_o <= 1'b0;
         usb_isout_o <= reg_read_o;
         case (state)
            FE_IDLE: begin
               if (wr_sel) begin
                  state       <= FE_WRITE;
                  reg_write_o <= 1'b1;
               end else if (rd_sel) begin
                  state <= FE_READ;
               end
            end
            FE_WRITE: if (!wr_sel) state <= FE_IDLE; // wait for strobe release
            FE_READ:  if (!rd_sel) state <= FE_IDLE;
            default:  state <= FE_IDLE;
         endcase
      end
   end

   always_ff @(posedge usb_clk_buf) begin
      if (reg_read_o) usb_data_o <= reg_rdata_i; // bank data one cycle after decode
   end

   a_no_rw_overlap: assert property (@(posedge usb_clk_buf) disable iff (reset)
      !(reg_write_o && reg_read_o));

endmodule

// ==== verilog/led_heartbeat.sv ====
`timescale 1ns/1ns
`include "bergen_defs.svh"

module led_heartbeat (
   input  logic                      usb_clk_buf,
   input  logic                      sysclk_i,
   input  bergen_bus_pkg::bus_byte_t reg_leds_i,
   input  logic                      hb_sel_i,
   output bergen_bus_pkg::bus_byte_t leds_o
);

   typedef logic [`BERGEN_HB_USB_W-1:0] hb_usb_t;
   typedef logic [`BERGEN_HB_SYS_W-1:0] hb_sys_t;

   hb_usb_t usb_hb_q;
   hb_sys_t sys_hb_q;

   // free running, only the top bit is ever looked at
   always_ff @(posedge usb_clk_buf) begin
      usb_hb_q <= usb_hb_q + hb_usb_t'(1);
   end

   always_ff @(posedge sysclk_i) begin
      sys_hb_q <= sys_hb_q + hb_sys_t'(1);
   end

   assign leds_o = hb_sel_i
      ? {6'b0, sys_hb_q[`BERGEN_HB_SYS_W-1], usb_hb_q[`BERGEN_HB_USB_W-1]}
      : reg_leds_i;

endmodule

// ==== verilog/bergen_top.sv ====
`timescale 1ns/1ns
`include "bergen_defs.svh"

module bergen_top #(
   parameter int FREQ_GATE_BIT = `BERGEN_FREQ_GATE_BIT
) (
   input  logic                      usb_clk_buf,
   input  logic                      reset,
   input  logic                      sysclk_i,
   input  bergen_bus_pkg::usb_addr_t usb_addr_i,
   input  bergen_bus_pkg::bus_byte_t usb_data_i,
   input  logic                      usb_nrd_i,
   input  logic                      usb_nwr_i,
   input  logic                      usb_nce_i,
   input  bergen_bus_pkg::bus_byte_t dip_i,
   output bergen_bus_pkg::bus_byte_t usb_data_o,
   output logic                      usb_isout_o,
   output bergen_bus_pkg::bus_byte_t leds_o
);
   import bergen_bus_pkg::*;
   import bergen_reg_pkg::*;

   reg_addr_t reg_addr;
   bytecnt_t  reg_bytecnt;
   bus_byte_t reg_wdata;
   bus_byte_t reg_rdata;
   bus_byte_t reg_leds;
   logic      reg_write;
   logic      reg_read;
   logic      hb_sel;
   freq_t     sysclk_freq;

   usb_reg_fe u_usb_reg_fe (
      .usb_clk_buf   (usb_clk_buf),
      .reset         (reset),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_nrd_i     (usb_nrd_i),
      .usb_nwr_i     (usb_nwr_i),
      .usb_nce_i     (usb_nce_i),
      .reg_rdata_i   (reg_rdata),
      .usb_data_o    (usb_data_o),
      .usb_isout_o   (usb_isout_o),
      .reg_addr_o    (reg_addr),
      .reg_bytecnt_o (reg_bytecnt),
      .reg_wdata_o   (reg_wdata),
      .reg_write_o   (reg_write),
      .reg_read_o    (reg_read)
   );

   bergen_reg_bank u_reg_bank (
      .usb_clk_buf   (usb_clk_buf),
      .reset         (reset),
      .reg_addr_i    (reg_addr),
      .reg_bytecnt_i (reg_bytecnt),
      .reg_wdata_i   (reg_wdata),
      .reg_write_i   (reg_write),
      .reg_read_i    (reg_read),
      .dip_i         (dip_i),
      .freq_i        (sysclk_freq),
      .reg_rdata_o   (reg_rdata),
      .reg_leds_o    (reg_leds),
      .hb_sel_o      (hb_sel)
   );

   sysclk_freq_meter #(
      .FREQ_GATE_BIT (FREQ_GATE_BIT)
   ) u_freq_meter (
      .usb_clk_buf   (usb_clk_buf),
      .reset         (reset),
      .sysclk_i      (sysclk_i),
      .freq_o        (sysclk_freq)
   );

   led_heartbeat u_led_heartbeat (
      .usb_clk_buf   (usb_clk_buf),
      .sysclk_i      (sysclk_i),
      .reg_leds_i    (reg_leds),
      .hb_sel_i      (hb_sel),
      .leds_o        (leds_o)
   );

endmodule

// ==== test/tb_bergen_top.sv ====
`timescale 1ns/1ns
`include "bergen_defs.svh"

module tb_bergen_top;
   import bergen_bus_pkg::*;

   localparam int GATE_BIT      = 7; // 256 usb cycles per gate
   localparam int GATE_CYCLES   = 2 ** (GATE_BIT + 1);
   localparam int DRIVE_DELAY   = 10;
   localparam int READ_HOLD     = 4;
   localparam int ISOUT_TIMEOUT = 16;
   localparam int FREQ_TRIES    = 8;
   localparam int NAME_W        = 8 * 24;
   localparam int LINE_W        = 8 * 128;

   logic      usb_clk_buf;
   logic      reset;
   logic      sysclk;
   usb_addr_t usb_addr;
   bus_byte_t usb_data_in;
   logic      usb_nrd;
   logic      usb_nwr;
   logic      usb_nce;
   bus_byte_t dip;
   bus_byte_t usb_data_out;
   logic      usb_isout;
   bus_byte_t leds;

   int error_count;
   int check_count;
   int cycle_count; // usb cycles since reset release

   bergen_top #(
      .FREQ_GATE_BIT (GATE_BIT)
   ) u_dut (
      .usb_clk_buf (usb_clk_buf),
      .reset       (reset),
      .sysclk_i    (sysclk),
      .usb_addr_i  (usb_addr),
      .usb_data_i  (usb_data_in),
      .usb_nrd_i   (usb_nrd),
      .usb_nwr_i   (usb_nwr),
      .usb_nce_i   (usb_nce),
      .dip_i       (dip),
      .usb_data_o  (usb_data_out),
      .usb_isout_o (usb_isout),
      .leds_o      (leds)
   );

   initial begin
      usb_clk_buf = 1'b0;
      forever #50 usb_clk_buf = ~usb_clk_buf;
   end

   initial begin
      sysclk = 1'b0;
      forever #15 sysclk = ~sysclk; // 30 ns, about 853 per gate
   end

   always @(posedge usb_clk_buf) begin
      if (reset) cycle_count <= 0;
      else cycle_count <= cycle_count + 1;
   end

   task automatic drive_step;
      @(posedge usb_clk_buf);
      #DRIVE_DELAY;
   endtask

   task automatic check_value(input logic [NAME_W-1:0] name,
                              input logic [31:0] expected,
                              input logic [31:0] actual,
                              input int tol);
      logic [31:0] diff;
      check_count++;
      diff = (actual > expected) ? actual - expected : expected - actual;
      if ($isunknown(actual) || diff > 32'(tol)) begin
         $display("Mismatch in %0s: expected 0x%0h (tolerance %0d), actual 0x%0h",
                  name, expected, tol, actual);
         error_count++;
      end
   endtask

   task automatic bus_write(input reg_addr_t regnum, input bytecnt_t idx,
                            input bus_byte_t data);
      drive_step;
      usb_addr    = {regnum, idx};
      usb_data_in = data;
      usb_nce     = 1'b0;
      usb_nwr     = 1'b0;
      repeat (3) drive_step; // sampled, write pulse, register updated
      usb_nwr = 1'b1;
      usb_nce = 1'b1;
      repeat (3) drive_step;
   endtask

   task automatic bus_read(input reg_addr_t regnum, input bytecnt_t idx,
                           output bus_byte_t data, output logic ok);
      int waited;
      drive_step;
      usb_addr = {regnum, idx};
      usb_nce  = 1'b0;
      usb_nrd  = 1'b0;
      repeat (READ_HOLD) drive_step;
      waited = 0;
      while (usb_isout !== 1'b1 && waited < ISOUT_TIMEOUT) begin
         drive_step;
         waited++;
      end
      ok = (usb_isout === 1'b1);
      if (!ok) begin
         $display("usb_isout_o never went high while reading register %0d", regnum);
         error_count++;
      end
      data    = usb_data_out;
      usb_nrd = 1'b1;
      usb_nce = 1'b1;
      repeat (3) drive_step; // let isout fall before the next cycle
   endtask

   task automatic read_freq(input reg_addr_t regnum, output logic [`BERGEN_FREQ_W-1:0] value);
      bus_byte_t b;
      logic      ok;
      for (int i = 0; i < 4; i++) begin
         bus_read(regnum, bytecnt_t'(i), b, ok);
         value[8*i +: 8] = ok ? b : 8'hxx; // lsb at byte 0
      end
   endtask

   task automatic check_freq(input logic [NAME_W-1:0] name, input reg_addr_t regnum,
                             input logic [31:0] expected, input int tol);
      logic [`BERGEN_FREQ_W-1:0] value;
      int waited;
      int tries;
      waited = 0;
      while (cycle_count < 3 * GATE_CYCLES && waited < 4 * GATE_CYCLES) begin
         drive_step;
         waited++;
      end
      if (cycle_count < 3 * GATE_CYCLES) begin
         $display("gave up waiting for three gate periods before the frequency read");
         error_count++;
      end
      tries = 0;
      read_freq(regnum, value);
      while ($isunknown(value) && tries < FREQ_TRIES) begin
         read_freq(regnum, value);
         tries++;
      end
      check_value(name, expected, value, tol);
   endtask

   task automatic run_op(input logic [NAME_W-1:0] op, input logic [NAME_W-1:0] name,
                         input logic [31:0] regnum, input logic [31:0] idx,
                         input logic [31:0] value, input int tol);
      bus_byte_t rd;
      bus_byte_t mask;
      logic      ok;
      mask = regnum[7:0];
      if (op == "write") begin
         bus_write(reg_addr_t'(regnum), bytecnt_t'(idx), value[7:0]);
      end else if (op == "read") begin
         bus_read(reg_addr_t'(regnum), bytecnt_t'(idx), rd, ok);
         if (ok) check_value(name, value, {24'b0, rd}, tol);
      end else if (op == "leds") begin
         check_value(name, {24'b0, value[7:0] & mask}, {24'b0, leds & mask}, tol);
      end else if (op == "dip") begin
         dip = value[7:0];
         drive_step;
      end else if (op == "freq") begin
         check_freq(name, reg_addr_t'(regnum), value, tol);
      end else begin
         $display("unknown operation %0s in the golden file", op);
         error_count++;
      end
   endtask

   initial begin
      int                 fd;
      int                 code;
      int                 fields;
      int                 tol;
      logic [LINE_W-1:0]  line;
      logic [NAME_W-1:0]  op;
      logic [NAME_W-1:0]  name;
      logic [31:0]        regnum;
      logic [31:0]        idx;
      logic [31:0]        value;
      reset       = 1'b1;
      usb_addr    = '0;
      usb_data_in = '0;
      usb_nrd     = 1'b1;
      usb_nwr     = 1'b1;
      usb_nce     = 1'b1;
      dip         = '0;
      error_count = 0;
      check_count = 0;
      repeat (8) @(posedge usb_clk_buf);
      #DRIVE_DELAY reset = 1'b0;
      drive_step;
      check_value("reset_isout", 32'd0, {31'b0, usb_isout}, 0);
      fd = $fopen("test/bergen_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open test/bergen_golden.txt");
         error_count++;
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            op   = '0;
            code = $fgets(line, fd);
            fields = $sscanf(line, "%s %s %h %h %h %d", op, name, regnum, idx, value, tol);
            if (code <= 0 || fields <= 0 || op == "#") begin
               // blank or comment line
            end else if (fields != 6) begin
               $display("malformed line in the golden file: %0s", line);
               error_count++;
            end else begin
               run_op(op, name, regnum, idx, value, tol);
            end
         end
         $fclose(fd);
      end
      $display("checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== test/bergen_golden.txt ====
# op name reg byte value tol (reg, byte, value in hex; tol in decimal)
# read/freq expect value, write stores it, dip drives dip_i, leds uses reg as bit mask
leds  reset_leds    ff  0  00   0
read  ident_rd      0   0  2e   0
write leds_wr       1   0  a5   0
read  leds_rd       1   0  a5   0
leds  leds_out      ff  0  a5   0
write hb_on         2   0  01   0
read  hb_sel_rd     2   0  01   0
leds  hb_leds       fc  0  00   0
write hb_off        2   0  00   0
read  hb_off_rd     2   0  00   0
leds  hb_off_leds   ff  0  a5   0
write leds_wr2      1   0  3c   0
leds  leds_out2     ff  0  3c   0
dip   dip_set       0   0  5a   0
read  dip_rd        3   0  5a   0
dip   dip_set2      0   0  c3   0
read  dip_rd2       3   0  c3   0
read  unused_rd     7   0  00   0
read  unused_rd2    1f  0  00   0
freq  sysclk_freq   4   0  355  2

// ==== bergen.f ====
+incdir+common
common/bergen_bus_pkg.sv
common/bergen_reg_pkg.sv
freq/cdc_pulse.sv
freq/sysclk_freq_meter.sv
regs/bergen_reg_bank.sv
verilog/usb_reg_fe.sv
verilog/led_heartbeat.sv
verilog/bergen_top.sv
test/tb_bergen_top.sv

// ==== Makefile ====
# Verilator build and run for the bergen register testbench

TOP             ?= tb_bergen_top
FILELIST        ?= bergen.f
VERILATOR       ?= verilator
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
PASS_MSG        := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP FILELIST VERILATOR OBJ_DIR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
